//--- logic/serv_lite_pkg.sv
package serv_lite_pkg;

   // Bus address, instruction or bus data
   typedef logic [31:0] word_t;

   typedef logic [4:0] reg_addr_t;

   // Bit position within the serial word, LSB first
   typedef logic [4:0] bit_cnt_t;

   typedef logic [1:0] bool_op_t;

   localparam bool_op_t BOOL_ADD = 2'b00;
   localparam bool_op_t BOOL_XOR = 2'b01;
   localparam bool_op_t BOOL_OR  = 2'b10;
   localparam bool_op_t BOOL_AND = 2'b11;

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_INIT,
      PH_MEM,
      PH_RUN
   } phase_t;

endpackage

//--- logic/serv_lite_state.sv
module serv_lite_state import serv_lite_pkg::*; (
   input  logic     clk,
   input  logic     i_reset,
   input  logic     i_ibus_ack,
   input  logic     i_dbus_ack,
   input  logic     i_two_phase,
   input  logic     i_mem_op,
   output logic     o_ibus_cyc,
   output logic     o_dbus_cyc,
   output logic     o_init,
   output logic     o_run,
   output logic     o_cnt_done,
   output bit_cnt_t o_cnt
);

   phase_t   phase;
   bit_cnt_t cnt;

   assign o_ibus_cyc = (phase == PH_FETCH);
   assign o_dbus_cyc = (phase == PH_MEM);
   assign o_init     = (phase == PH_INIT);
   assign o_run      = (phase == PH_RUN);
   assign o_cnt      = cnt;
   assign o_cnt_done = (cnt == 5'd31);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase <= PH_FETCH;
         cnt   <= '0;
      end else begin
         // Counter wraps to zero at the end of each serial phase
         if (o_init || o_run)
            cnt <= cnt + 5'd1;

         case (phase)
            PH_FETCH: begin
               // Branches and memory ops need operands before the run phase
               if (i_ibus_ack)
                  phase <= i_two_phase ? PH_INIT : PH_RUN;
            end
            PH_INIT: begin
               if (o_cnt_done)
                  phase <= i_mem_op ? PH_MEM : PH_RUN;
            end
            PH_MEM: begin
               if (i_dbus_ack)
                  phase <= PH_RUN;
            end
            default: begin
               if (o_cnt_done)
                  phase <= PH_FETCH;
            end
         endcase
      end
   end

endmodule

//--- logic/serv_lite_decode.sv
module serv_lite_decode import serv_lite_pkg::*; (
   input  logic      clk,
   input  logic      i_ibus_ack,
   input  word_t     i_ibus_rdt,
   input  bit_cnt_t  i_cnt,
   input  logic      i_run,
   output logic      o_two_phase,
   output logic      o_mem_op,
   output logic      o_we,
   output logic      o_branch,
   output logic      o_bne,
   output logic      o_jal,
   output logic      o_lui,
   output logic      o_op_b_imm,
   output logic      o_sub,
   output bool_op_t  o_bool_op,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output reg_addr_t o_rd_addr,
   output logic      o_rd_wen,
   output logic      o_rd_sel_alu,
   output logic      o_rd_sel_ctrl,
   output logic      o_rd_sel_mem,
   output logic      o_imm
);

   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;

   word_t      insn_q;
   word_t      insn;
   word_t      imm_w;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_addi;
   logic       is_reg;
   logic       is_lui;
   logic       is_beq;
   logic       is_bne;
   logic       is_jal;
   logic       is_lw;
   logic       is_sw;

   always_ff @(posedge clk) begin
      if (i_ibus_ack)
         insn_q <= i_ibus_rdt;
   end

   // Fresh word is decoded during the ack so the FSM can choose its next phase
   assign insn   = i_ibus_ack ? i_ibus_rdt : insn_q;
   assign opcode = insn[6:0];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];

   assign is_addi = (opcode == OP_IMM) && (funct3 == 3'b000);
   assign is_reg  = (opcode == OP_REG) &&
                    (((funct7 == 7'b0000000) && (funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}))
                     || ((funct7 == 7'b0100000) && (funct3 == 3'b000)));
   assign is_lui  = (opcode == OP_LUI);
   assign is_beq  = (opcode == OP_BRANCH) && (funct3 == 3'b000);
   assign is_bne  = (opcode == OP_BRANCH) && (funct3 == 3'b001);
   assign is_jal  = (opcode == OP_JAL);
   assign is_lw   = (opcode == OP_LOAD) && (funct3 == 3'b010);
   assign is_sw   = (opcode == OP_STORE) && (funct3 == 3'b010);

   assign o_branch    = is_beq | is_bne;
   assign o_bne       = is_bne;
   assign o_jal       = is_jal;
   assign o_lui       = is_lui;
   assign o_mem_op    = is_lw | is_sw;
   assign o_we        = is_sw;
   assign o_two_phase = o_branch | o_mem_op;
   assign o_op_b_imm  = is_addi;
   assign o_sub       = is_reg & funct7[5];

   always_comb begin
      o_bool_op = BOOL_ADD;
      if (is_reg) begin
         case (funct3)
            3'b100:  o_bool_op = BOOL_XOR;
            3'b110:  o_bool_op = BOOL_OR;
            3'b111:  o_bool_op = BOOL_AND;
            default: o_bool_op = BOOL_ADD;
         endcase
      end
   end

   assign o_rs1_addr = insn[19:15];
   assign o_rs2_addr = insn[24:20];
   assign o_rd_addr  = insn[11:7];

   assign o_rd_sel_alu  = is_addi | is_reg | is_lui;
   assign o_rd_sel_ctrl = is_jal;
   assign o_rd_sel_mem  = is_lw;

   // x0 is never written
   assign o_rd_wen = i_run && (o_rd_addr != '0) &&
                     (o_rd_sel_alu | o_rd_sel_ctrl | o_rd_sel_mem);

   always_comb begin
      if (is_lui)
         imm_w = {insn[31:12], 12'b0};
      else if (is_jal)
         imm_w = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      else if (o_branch)
         imm_w = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      else if (is_sw)
         imm_w = {{21{insn[31]}}, insn[30:25], insn[11:7]};
      else
         imm_w = {{21{insn[31]}}, insn[30:20]};
   end

   assign o_imm = imm_w[i_cnt];

endmodule

//--- logic/serv_lite_alu.sv
module serv_lite_alu import serv_lite_pkg::*; (
   input  logic     clk,
   input  logic     i_init,
   input  logic     i_run,
   input  logic     i_cnt_done,
   input  logic     i_rs1,
   input  logic     i_rs2,
   input  logic     i_imm,
   input  logic     i_op_b_imm,
   input  logic     i_sub,
   input  logic     i_lui,
   input  bool_op_t i_bool_op,
   output logic     o_rd,
   output logic     o_eq
);

   logic op_b;
   logic b_add;
   logic sum;
   logic carry;
   logic carry_q;
   logic neq_q;
   logic result;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   assign b_add = op_b ^ i_sub;
   assign sum   = i_rs1 ^ b_add ^ carry_q;
   assign carry = (i_rs1 & b_add) | (carry_q & (i_rs1 ^ b_add));

   always_comb begin
      case (i_bool_op)
         BOOL_XOR: result = i_rs1 ^ op_b;
         BOOL_OR:  result = i_rs1 | op_b;
         BOOL_AND: result = i_rs1 & op_b;
         default:  result = sum;
      endcase
   end

   assign o_rd = i_lui ? i_imm : result;
   assign o_eq = ~neq_q;

   always_ff @(posedge clk) begin
      // Two's complement subtract starts with a carry in on bit 0
      if (i_run && !i_cnt_done)
         carry_q <= carry;
      else
         carry_q <= i_sub;

      // Mismatch flag, held through the run phase for the branch decision
      if (i_init)
         neq_q <= neq_q | (i_rs1 ^ i_rs2);
      else if (!i_run)
         neq_q <= 1'b0;
   end

endmodule

//--- logic/serv_lite_ctrl.sv
module serv_lite_ctrl import serv_lite_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  i_reset,
   input  logic  i_run,
   input  logic  i_cnt_done,
   input  logic  i_branch,
   input  logic  i_bne,
   input  logic  i_jal,
   input  logic  i_eq,
   input  logic  i_imm,
   input  logic  i_ibus_ack,
   output word_t o_ibus_adr,
   output logic  o_rd
);

   word_t      pc;
   word_t      pc_sh;
   logic [2:0] four_q;
   logic       pc_bit;
   logic       sum4;
   logic       c4;
   logic       c4_q;
   logic       sum_imm;
   logic       c_imm;
   logic       c_imm_q;
   logic       take;
   logic       next_bit;

   assign pc_bit  = pc_sh[0];
   assign sum4    = pc_bit ^ four_q[0] ^ c4_q;
   assign c4      = (pc_bit & four_q[0]) | (c4_q & (pc_bit ^ four_q[0]));
   assign sum_imm = pc_bit ^ i_imm ^ c_imm_q;
   assign c_imm   = (pc_bit & i_imm) | (c_imm_q & (pc_bit ^ i_imm));

   assign take     = i_jal | (i_branch & (i_eq ^ i_bne));
   assign next_bit = take ? sum_imm : sum4;

   // PC+4 doubles as the JAL link value
   assign o_rd       = sum4;
   assign o_ibus_adr = pc;

   always_ff @(posedge clk) begin
      // PC bits shift out at the bottom while the target shifts in at the top
      if (i_ibus_ack) begin
         pc_sh  <= pc;
         four_q <= 3'b100;
      end else if (i_run) begin
         pc_sh  <= {next_bit, pc_sh[31:1]};
         four_q <= {1'b0, four_q[2:1]};
      end

      if (i_run && !i_cnt_done) begin
         c4_q    <= c4;
         c_imm_q <= c_imm;
      end else begin
         c4_q    <= 1'b0;
         c_imm_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         pc <= RESET_PC;
      else if (i_run && i_cnt_done)
         pc <= {next_bit, pc_sh[31:1]};
   end

endmodule

//--- logic/serv_lite_rf.sv
module serv_lite_rf import serv_lite_pkg::*; (
   input  logic      clk,
   input  bit_cnt_t  i_cnt,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  reg_addr_t i_rd_addr,
   input  logic      i_rd_wen,
   input  logic      i_rd,
   output logic      o_rs1,
   output logic      o_rs2
);

   // x1 to x31, x0 has no storage
   word_t regs [1:31];

   logic rs1_zero;
   logic rs2_zero;
   logic rd_zero;

   assign rs1_zero = (i_rs1_addr == '0);
   assign rs2_zero = (i_rs2_addr == '0);
   assign rd_zero  = (i_rd_addr == '0);

   // Reads see the value from before this cycle's write
   assign o_rs1 = rs1_zero ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = rs2_zero ? 1'b0 : regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_rd_wen && !rd_zero)
         regs[i_rd_addr][i_cnt] <= i_rd;
   end

endmodule

//--- logic/serv_lite_mem_if.sv
module serv_lite_mem_if import serv_lite_pkg::*; (
   input  logic  clk,
   input  logic  i_init,
   input  logic  i_run,
   input  logic  i_cnt_done,
   input  logic  i_rs1,
   input  logic  i_rs2,
   input  logic  i_imm,
   input  logic  i_dbus_ack,
   input  word_t i_dbus_rdt,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat,
   output logic  o_rd
);

   word_t adr_q;
   word_t dat_q;
   word_t rdt_q;
   logic  sum;
   logic  carry;
   logic  carry_q;

   // Effective address rs1 + imm
   assign sum   = i_rs1 ^ i_imm ^ carry_q;
   assign carry = (i_rs1 & i_imm) | (carry_q & (i_rs1 ^ i_imm));

   // Word accesses only
   assign o_dbus_adr = {adr_q[31:2], 2'b00};
   assign o_dbus_dat = dat_q;
   assign o_rd       = rdt_q[0];

   always_ff @(posedge clk) begin
      if (i_init) begin
         adr_q <= {sum, adr_q[31:1]};
         dat_q <= {i_rs2, dat_q[31:1]};
      end

      if (i_init && !i_cnt_done)
         carry_q <= carry;
      else
         carry_q <= 1'b0;

      // Load data shifts out LSB first during run
      if (i_dbus_ack)
         rdt_q <= i_dbus_rdt;
      else if (i_run)
         rdt_q <= {1'b0, rdt_q[31:1]};
   end

endmodule

//--- logic/serv_lite_top.sv
module serv_lite_top import serv_lite_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  i_reset,
   output word_t o_ibus_adr,
   output logic  o_ibus_cyc,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat,
   output logic  o_dbus_we,
   output logic  o_dbus_cyc,
   input  word_t i_dbus_rdt,
   input  logic  i_dbus_ack
);

   logic      ibus_ack;
   logic      dbus_ack;
   logic      init;
   logic      run;
   logic      cnt_done;
   bit_cnt_t  cnt;
   logic      two_phase;
   logic      mem_op;
   logic      branch;
   logic      bne;
   logic      jal;
   logic      lui;
   logic      op_b_imm;
   logic      sub;
   bool_op_t  bool_op;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   logic      rd_wen;
   logic      rd_sel_alu;
   logic      rd_sel_ctrl;
   logic      rd_sel_mem;
   logic      imm;
   logic      rs1;
   logic      rs2;
   logic      alu_rd;
   logic      ctrl_rd;
   logic      mem_rd;
   logic      eq;
   logic      rd;

   // Acks only count while a cycle is requested
   assign ibus_ack = o_ibus_cyc & i_ibus_ack;
   assign dbus_ack = o_dbus_cyc & i_dbus_ack;

   assign rd = (rd_sel_alu & alu_rd) | (rd_sel_ctrl & ctrl_rd) | (rd_sel_mem & mem_rd);

   serv_lite_state state (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_ibus_ack  (ibus_ack),
      .i_dbus_ack  (dbus_ack),
      .i_two_phase (two_phase),
      .i_mem_op    (mem_op),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_dbus_cyc  (o_dbus_cyc),
      .o_init      (init),
      .o_run       (run),
      .o_cnt_done  (cnt_done),
      .o_cnt       (cnt)
   );

   serv_lite_decode decode (
      .clk           (clk),
      .i_ibus_ack    (ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_cnt         (cnt),
      .i_run         (run),
      .o_two_phase   (two_phase),
      .o_mem_op      (mem_op),
      .o_we          (o_dbus_we),
      .o_branch      (branch),
      .o_bne         (bne),
      .o_jal         (jal),
      .o_lui         (lui),
      .o_op_b_imm    (op_b_imm),
      .o_sub         (sub),
      .o_bool_op     (bool_op),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_wen      (rd_wen),
      .o_rd_sel_alu  (rd_sel_alu),
      .o_rd_sel_ctrl (rd_sel_ctrl),
      .o_rd_sel_mem  (rd_sel_mem),
      .o_imm         (imm)
   );

   serv_lite_alu alu (
      .clk        (clk),
      .i_init     (init),
      .i_run      (run),
      .i_cnt_done (cnt_done),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_op_b_imm (op_b_imm),
      .i_sub      (sub),
      .i_lui      (lui),
      .i_bool_op  (bool_op),
      .o_rd       (alu_rd),
      .o_eq       (eq)
   );

   serv_lite_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_run      (run),
      .i_cnt_done (cnt_done),
      .i_branch   (branch),
      .i_bne      (bne),
      .i_jal      (jal),
      .i_eq       (eq),
      .i_imm      (imm),
      .i_ibus_ack (ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd)
   );

   serv_lite_rf rf (
      .clk        (clk),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_wen   (rd_wen),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_lite_mem_if mem_if (
      .clk        (clk),
      .i_init     (init),
      .i_run      (run),
      .i_cnt_done (cnt_done),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_dbus_ack (dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_rd       (mem_rd)
   );

endmodule

//--- testbench/tb_serv_lite.sv
module tb_serv_lite import serv_lite_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam word_t RESET_PC  = 32'h0000_0200;
   localparam word_t DUMP_BASE = 32'h0000_0400;
   localparam int    BODY_END  = 55;
   localparam int    LOOP_IDX  = 86;
   localparam int    PROG_LEN  = 87;
   localparam int    RUN_LIMIT = 40000;

   logic  clk;
   logic  i_reset;
   word_t o_ibus_adr;
   logic  o_ibus_cyc;
   word_t i_ibus_rdt;
   logic  i_ibus_ack;
   word_t o_dbus_adr;
   word_t o_dbus_dat;
   logic  o_dbus_we;
   logic  o_dbus_cyc;
   word_t i_dbus_rdt;
   logic  i_dbus_ack;

   word_t prog [0:PROG_LEN-1];
   word_t dmem [word_t];
   word_t model_mem [word_t];
   word_t xr [0:31];
   word_t exp_fetch [$];
   word_t exp_adr [$];
   logic  exp_we [$];
   word_t exp_dat [$];
   word_t loop_pc;
   int    errors;
   int    passed;
   int    failed;
   bit    aborted;
   string names [0:4];

   serv_lite_top #(
      .RESET_PC (RESET_PC)
   ) uut (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Unwritten data memory hashed from the full address
   function automatic word_t fill_word(input word_t a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic int pick_delay(input int mode);
      if (mode == 1)
         return 0;
      if (mode == 2)
         return 5;
      return int'($urandom % 6);
   endfunction

   // Kinds 0 alu, 1 memory, 2 control flow, 3 mix, 4 mix with many x0 writes
   task automatic build_program(input int kind);
      int        i;
      int        sel;
      int        tgt;
      bit        use_mem;
      bit        use_ctl;
      word_t     r;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic [11:0] imm12;
      use_mem = (kind == 1) || (kind >= 3);
      use_ctl = (kind >= 2);
      // Prologue gives every register a known value
      for (i = 0; i < 31; i++) begin
         r = $urandom;
         prog[i] = enc_i(r[11:0], 5'd0, 3'b000, reg_addr_t'(i + 1), 7'b0010011);
      end
      for (i = 31; i < BODY_END; i++) begin
         r     = $urandom;
         rd    = r[4:0];
         rs1   = r[9:5];
         rs2   = r[14:10];
         imm12 = r[26:15];
         if (kind == 4 && r[27])
            rd = 5'd0;
         sel = int'($urandom % 10);
         if (sel == 9) begin
            r = $urandom;
            prog[i] = {r[31:7], 7'b1110011};
         end else if (sel >= 7 && use_ctl) begin
            tgt = i + 1 + int'($urandom % (BODY_END - i));
            if (r[30:29] == 2'b00)
               prog[i] = enc_j(21'((tgt - i) * 4), rd);
            else begin
               if (r[31])
                  rs2 = rs1;
               prog[i] = enc_b(13'((tgt - i) * 4), rs2, rs1, {2'b00, r[28]});
            end
         end else if (sel >= 5 && use_mem) begin
            if (r[28])
               prog[i] = enc_s(imm12, rs2, rs1);
            else
               prog[i] = enc_i(imm12, rs1, 3'b010, rd, 7'b0000011);
         end else begin
            case ($urandom % 7)
               0: prog[i] = enc_i(imm12, rs1, 3'b000, rd, 7'b0010011);
               1: prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
               2: prog[i] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
               3: prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
               4: prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
               5: prog[i] = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
               default: prog[i] = {r[31:12], rd, 7'b0110111};
            endcase
         end
      end
      // Register dump followed by a jump to itself
      for (i = 1; i < 32; i++)
         prog[BODY_END + i - 1] = enc_s(12'(DUMP_BASE + 4 * (i - 1)), reg_addr_t'(i), 5'd0);
      prog[LOOP_IDX] = enc_j(21'd0, 5'd0);
   endtask

   // Reference ISA model of the supported subset
   task automatic model_program();
      word_t pc;
      word_t nxt;
      word_t w;
      word_t a;
      word_t rs1v;
      word_t rs2v;
      word_t res;
      word_t imm_i;
      word_t imm_s;
      word_t imm_b;
      word_t imm_j;
      logic [2:0] f3;
      logic [6:0] f7;
      bit    wr;
      bit    stop;
      int    steps;
      for (int k = 0; k < 32; k++)
         xr[k] = '0;
      model_mem.delete();
      exp_fetch.delete();
      exp_adr.delete();
      exp_we.delete();
      exp_dat.delete();
      pc    = RESET_PC;
      stop  = 1'b0;
      steps = 0;
      while (!stop && steps < 1000) begin
         w     = prog[int'((pc - RESET_PC) >> 2)];
         exp_fetch.push_back(pc);
         f3    = w[14:12];
         f7    = w[31:25];
         rs1v  = xr[w[19:15]];
         rs2v  = xr[w[24:20]];
         imm_i = {{20{w[31]}}, w[31:20]};
         imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
         imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         nxt   = pc + 4;
         wr    = 1'b0;
         res   = '0;
         case (w[6:0])
            7'b0010011: begin
               wr  = (f3 == 3'b000);
               res = rs1v + imm_i;
            end
            7'b0110011: begin
               wr = 1'b1;
               if (f7 == 7'b0100000 && f3 == 3'b000)
                  res = rs1v - rs2v;
               else if (f7 == 7'b0000000 && f3 == 3'b000)
                  res = rs1v + rs2v;
               else if (f7 == 7'b0000000 && f3 == 3'b100)
                  res = rs1v ^ rs2v;
               else if (f7 == 7'b0000000 && f3 == 3'b110)
                  res = rs1v | rs2v;
               else if (f7 == 7'b0000000 && f3 == 3'b111)
                  res = rs1v & rs2v;
               else
                  wr = 1'b0;
            end
            7'b0110111: begin
               wr  = 1'b1;
               res = {w[31:12], 12'b0};
            end
            7'b1100011: begin
               if ((f3 == 3'b000 && rs1v == rs2v) || (f3 == 3'b001 && rs1v != rs2v))
                  nxt = pc + imm_b;
            end
            7'b1101111: begin
               wr  = 1'b1;
               res = pc + 4;
               nxt = pc + imm_j;
            end
            7'b0000011: begin
               if (f3 == 3'b010) begin
                  a   = (rs1v + imm_i) & ~32'h3;
                  res = model_mem.exists(a) ? model_mem[a] : fill_word(a);
                  wr  = 1'b1;
                  exp_adr.push_back(a);
                  exp_we.push_back(1'b0);
                  exp_dat.push_back(res);
               end
            end
            7'b0100011: begin
               if (f3 == 3'b010) begin
                  a = (rs1v + imm_s) & ~32'h3;
                  model_mem[a] = rs2v;
                  exp_adr.push_back(a);
                  exp_we.push_back(1'b1);
                  exp_dat.push_back(rs2v);
               end
            end
            default: ;
         endcase
         if (wr && w[11:7] != 5'd0)
            xr[w[11:7]] = res;
         stop = (nxt == pc);
         pc   = nxt;
         steps++;
      end
      loop_pc = pc;
   endtask

   // Modes 0 random delay, 1 immediate ack, 2 maximum delay
   task automatic run_dut(input string name, input int mode);
      int    start_errors;
      int    traffic;
      int    cycles;
      int    idly;
      int    ddly;
      int    idx;
      bit    ibusy;
      bit    dbusy;
      bit    done;
      logic  dwe;
      word_t iadr;
      word_t dadr;
      word_t ddat;
      start_errors = errors;
      traffic      = 0;
      dmem.delete();
      i_reset    = 1'b1;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      repeat (16) @(negedge clk);
      i_reset = 1'b0;
      @(posedge clk);
      @(negedge clk);
      check("o_ibus_cyc", 32'd1, 32'(o_ibus_cyc));
      check("o_ibus_adr", RESET_PC, o_ibus_adr);
      check("o_dbus_cyc", 32'd0, 32'(o_dbus_cyc));
      ibusy  = 1'b0;
      dbusy  = 1'b0;
      done   = 1'b0;
      cycles = 0;
      idly   = 0;
      ddly   = 0;
      while (!done && cycles < RUN_LIMIT) begin
         @(negedge clk);
         cycles++;
         i_ibus_ack = 1'b0;
         i_dbus_ack = 1'b0;
         if (!ibusy && o_ibus_cyc) begin
            if (exp_fetch.size() == 0) begin
               check("o_ibus_adr", loop_pc, o_ibus_adr);
               done = 1'b1;
            end else begin
               iadr = o_ibus_adr;
               check("o_ibus_adr", exp_fetch.pop_front(), iadr);
               ibusy = 1'b1;
               idly  = pick_delay(mode);
               traffic++;
            end
         end
         if (ibusy) begin
            check("o_ibus_cyc", 32'd1, 32'(o_ibus_cyc));
            check("o_ibus_adr", iadr, o_ibus_adr);
            if (idly == 0) begin
               idx = int'((iadr - RESET_PC) >> 2);
               if (iadr < RESET_PC || idx >= PROG_LEN) begin
                  $display("ERROR: fetch outside the program at %0t, address %h", $time, iadr);
                  errors++;
                  i_ibus_rdt = 32'h0000_0013;
               end else
                  i_ibus_rdt = prog[idx];
               i_ibus_ack = 1'b1;
               ibusy      = 1'b0;
            end else
               idly--;
         end
         if (!dbusy && o_dbus_cyc) begin
            dadr = o_dbus_adr;
            ddat = o_dbus_dat;
            dwe  = o_dbus_we;
            if (exp_adr.size() == 0) begin
               $display("ERROR: unexpected data bus cycle at %0t, address %h", $time, dadr);
               errors++;
            end else begin
               check("o_dbus_adr", exp_adr.pop_front(), dadr);
               check("o_dbus_we", 32'(exp_we.pop_front()), 32'(o_dbus_we));
               if (o_dbus_we)
                  check("o_dbus_dat", exp_dat.pop_front(), o_dbus_dat);
               else
                  void'(exp_dat.pop_front());
            end
            dbusy = 1'b1;
            ddly  = pick_delay(mode);
            traffic++;
         end
         if (dbusy) begin
            check("o_dbus_cyc", 32'd1, 32'(o_dbus_cyc));
            check("o_dbus_adr", dadr, o_dbus_adr);
            check("o_dbus_we", 32'(dwe), 32'(o_dbus_we));
            check("o_dbus_dat", ddat, o_dbus_dat);
            if (ddly == 0) begin
               if (o_dbus_we)
                  dmem[dadr] = o_dbus_dat;
               else
                  i_dbus_rdt = dmem.exists(dadr) ? dmem[dadr] : fill_word(dadr);
               i_dbus_ack = 1'b1;
               dbusy      = 1'b0;
            end else
               ddly--;
         end
      end
      if (!done) begin
         $display("ERROR: test %s did not reach the end of its program in %0d cycles",
                  name, RUN_LIMIT);
         errors++;
         aborted = 1'b1;
      end else
         check("data bus cycles left", 32'd0, 32'(exp_adr.size()));
      if (errors == start_errors) begin
         passed++;
         $display("test %-8s pass, %0d bus cycles", name, traffic);
      end else begin
         failed++;
         $display("test %-8s fail, %0d errors", name, errors - start_errors);
      end
   endtask

   initial begin
      i_reset    = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      errors     = 0;
      passed     = 0;
      failed     = 0;
      aborted    = 1'b0;
      names[0]   = "alu";
      names[1]   = "memory";
      names[2]   = "control";
      names[3]   = "mix";
      names[4]   = "x0";
      void'($urandom(32'h6501a393));

      for (int k = 0; k < 5; k++) begin
         if (!aborted) begin
            build_program(k);
            model_program();
            run_dut(names[k], 0);
         end
      end
      // Same program under immediate and maximum ack delay
      if (!aborted) begin
         build_program(3);
         model_program();
         run_dut("bp_fast", 1);
      end
      if (!aborted) begin
         model_program();
         run_dut("bp_slow", 2);
      end

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0 && !aborted)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- all.f
logic/serv_lite_pkg.sv
logic/serv_lite_state.sv
logic/serv_lite_decode.sv
logic/serv_lite_alu.sv
logic/serv_lite_ctrl.sv
logic/serv_lite_rf.sv
logic/serv_lite_mem_if.sv
logic/serv_lite_top.sv
testbench/tb_serv_lite.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the serv_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_serv_lite \
   -f all.f --Mdir obj_dir -o sim_serv_lite > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/sim_serv_lite > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
if ! grep -q "Test OK" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0
